// File: all.f
logic/kb_pkg.sv
logic/md5_block.sv
logic/aes_dec_core.sv
logic/key_check.sv
tb/key_check_properties.sv
tb/key_check_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the key_check testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module key_check_tb \
    -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vkey_check_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: tb/key_check_tb.sv
module key_check_tb import kb_pkg::*; ();

    localparam int num_tests   = 8;
    localparam int cycle_limit = num_tests * (104 + 20) + 200;

    logic      clk;
    logic      rst;
    logic      stall;
    logic      start;
    block128_t in_buf;
    kb_t       kb;
    block128_t key;
    logic      valid;
    logic      done;

    logic      exp_valid;    // read by the bound properties
    block128_t exp_key;
    int        assert_fails;
    int        fails_before;
    int        test_count;
    int        failed_tests;
    int        cycle_count;
    word_t     rng_state;

    key_check u_key_check (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .start  (start),
        .in_buf (in_buf),
        .kb     (kb),
        .key    (key),
        .valid  (valid),
        .done   (done)
    );

    bind key_check key_check_properties u_props (
        .clk(clk), .rst(rst), .stall(stall), .start(start), .state(state),
        .key(key), .valid(valid), .done(done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no done after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic kb_t rand_kb();
        kb_t k;
        for (int i = 0; i < 14; i++)
            k[32 * i +: 32] = next_rand();
        return k;
    endfunction

    // single block, iv start, pad words fixed
    function automatic block128_t model_md5(kb_t k);
        word_t m [16];
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t f;
        word_t t;
        word_t nb;
        for (int i = 0; i < 14; i++)
            m[i] = k[32 * i +: 32];
        m[14] = md5_pad14;
        m[15] = md5_pad15;
        a = md5_iv_a;
        b = md5_iv_b;
        c = md5_iv_c;
        d = md5_iv_d;
        for (int i = 0; i < 64; i++) begin
            if (i < 16)
                f = (b & c) | (~b & d);
            else if (i < 32)
                f = (b & d) | (c & ~d);
            else if (i < 48)
                f = b ^ c ^ d;
            else
                f = c ^ (b | ~d);
            t  = a + f + md5_k(6'(i)) + m[md5_g(6'(i))];
            nb = b + ((t << md5_s(6'(i))) | (t >> (32 - md5_s(6'(i)))));
            a  = d;
            d  = c;
            c  = b;
            b  = nb;
        end
        return {a + md5_iv_a, b + md5_iv_b, c + md5_iv_c, d + md5_iv_d};
    endfunction

    function automatic block128_t model_aes_enc(block128_t pt, block128_t k);
        word_t     w [44];
        word_t     t;
        block128_t st;
        block128_t sr;
        byte_t     a [4];
        for (int i = 0; i < 4; i++)
            w[i] = k[127 - 32 * i -: 32];
        for (int i = 4; i < 44; i++) begin
            t = w[i - 1];
            if (i % 4 == 0)
                t = {aes_sbox(t[23:16]), aes_sbox(t[15:8]), aes_sbox(t[7:0]),
                     aes_sbox(t[31:24])} ^ {aes_rcon(4'(i / 4)), 24'h0};
            w[i] = w[i - 4] ^ t;
        end
        st = pt ^ {w[0], w[1], w[2], w[3]};
        for (int rnd = 1; rnd <= 10; rnd++) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++)
                    sr[127 - 8 * (4 * c + r) -: 8] =
                        aes_sbox(st[127 - 8 * (4 * ((c + r) % 4) + r) -: 8]);  // shift rows
            end
            if (rnd < 10) begin
                for (int c = 0; c < 4; c++) begin
                    for (int r = 0; r < 4; r++)
                        a[r] = sr[127 - 32 * c - 8 * r -: 8];
                    sr[127 - 32 * c -: 32] = {
                        gf_mul(a[0], 8'h02) ^ gf_mul(a[1], 8'h03) ^ a[2] ^ a[3],
                        a[0] ^ gf_mul(a[1], 8'h02) ^ gf_mul(a[2], 8'h03) ^ a[3],
                        a[0] ^ a[1] ^ gf_mul(a[2], 8'h02) ^ gf_mul(a[3], 8'h03),
                        gf_mul(a[0], 8'h03) ^ a[1] ^ a[2] ^ gf_mul(a[3], 8'h02)};
                end
            end
            st = sr ^ {w[4 * rnd], w[4 * rnd + 1], w[4 * rnd + 2], w[4 * rnd + 3]};
        end
        return st;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // expected values change only after the previous done was sampled
    task automatic launch(input kb_t k, input block128_t ct, input logic ev, input block128_t ek);
        kb     = k;
        in_buf = ct;
        start  = 1'b1;
        idle_cycles(1);
        start     = 1'b0;
        exp_valid = ev;
        exp_key   = ek;
    endtask

    task automatic wait_done();
        while (done !== 1'b1)
            idle_cycles(1);
    endtask

    task automatic end_test(input string name);
        idle_cycles(1);  // lets the done checks fire
        test_count = test_count + 1;
        if (assert_fails == fails_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %0d %s: FAILED", test_count, name);
        end
        fails_before = assert_fails;
    endtask

    initial begin
        kb_t       k_a;
        kb_t       k_b;
        block128_t h_a;
        block128_t h_b;
        word_t     r;
        int        stall_left;
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        start        = 1'b0;
        in_buf       = '0;
        kb           = '0;
        exp_valid    = 1'b0;
        exp_key      = '0;
        assert_fails = 0;
        fails_before = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        rng_state    = 32'h8303;
        idle_cycles(3);
        rst = 1'b0;

        for (int i = 0; i < 3; i++) begin
            k_a = rand_kb();
            h_a = model_md5(k_a);
            launch(k_a, model_aes_enc(h_a, h_a), 1'b1, h_a);
            wait_done();
            end_test("matching candidate");
        end

        k_a = rand_kb();
        h_a = model_md5(k_a);
        r   = next_rand();
        launch(k_a, model_aes_enc(h_a, h_a) ^ (block128_t'(1) << r[6:0]), 1'b0, '0);
        wait_done();
        end_test("flipped ciphertext bit");

        k_a = rand_kb();
        k_b = rand_kb();
        h_b = model_md5(k_b);
        launch(k_a, model_aes_enc(h_b, h_b), 1'b0, '0);
        wait_done();
        end_test("ciphertext of another basis");

        k_a = rand_kb();
        h_a = model_md5(k_a);
        launch(k_a, model_aes_enc(h_a, h_a), 1'b1, h_a);
        idle_cycles(30);
        stall_left = 15;
        while (stall_left > 0) begin
            r     = next_rand();
            stall = r[0];
            if (r[0])
                stall_left = stall_left - 1;
            idle_cycles(1);
        end
        stall = 1'b0;
        wait_done();
        stall = 1'b1;  // done pulse stretched by the stall
        idle_cycles(2);
        stall = 1'b0;
        end_test("stalled run");

        k_a = rand_kb();
        h_a = model_md5(k_a);
        k_b = rand_kb();
        h_b = model_md5(k_b);
        launch(k_a, model_aes_enc(h_a, h_a), 1'b1, h_a);
        idle_cycles(20);
        kb     = k_b;
        in_buf = model_aes_enc(h_b, h_b);
        start  = 1'b1;  // controller busy, must be ignored
        idle_cycles(1);
        start = 1'b0;
        wait_done();
        end_test("start while busy");

        k_a = rand_kb();
        h_a = model_md5(k_a);
        k_b = rand_kb();
        h_b = model_md5(k_b);
        launch(k_a, model_aes_enc(h_a, h_a), 1'b1, h_a);
        wait_done();
        launch(k_b, model_aes_enc(h_b, h_b) ^ 128'h1, 1'b0, '0);
        wait_done();
        end_test("back to back");

        $display("tests: %0d, failed tests: %0d, assertion failures: %0d",
                 test_count, failed_tests, assert_fails);
        if (assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tb/key_check_properties.sv
module key_check_properties import kb_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      stall,
    input logic      start,
    input logic [1:0] state,
    input block128_t key,
    input logic      valid,
    input logic      done
);

    logic [7:0] run_cnt;    // unstalled cycles since the accepted start
    logic       accept;

    assign accept = start && (state == 2'd0);  // controller idle

    always_ff @(posedge clk) begin
        if (rst) begin
            run_cnt <= '0;
        end else if (!stall) begin
            if (accept)
                run_cnt <= 8'd1;
            else if (done)
                run_cnt <= '0;
            else if ((run_cnt != 8'd0) && (run_cnt != 8'hff))
                run_cnt <= run_cnt + 8'd1;
        end
    end

    valid_value: assert property (@(posedge clk) disable iff (rst)
        done |-> (valid == key_check_tb.exp_valid))
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("MISMATCH valid: got %h expected %h", valid, key_check_tb.exp_valid);
    end

    key_value: assert property (@(posedge clk) disable iff (rst)
        done |-> (key == key_check_tb.exp_key))
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("MISMATCH key: got %h expected %h", key, key_check_tb.exp_key);
    end

    // 104 cycles plus one for the sampling edge
    done_latency: assert property (@(posedge clk) disable iff (rst)
        done |-> (run_cnt == 8'd105))
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("done came %0d unstalled cycles after start instead of 104", run_cnt - 8'd1);
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> (!done && !valid && (key == '0)))
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("done, valid or key not cleared by reset");
    end

    stall_freeze: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(key) && $stable(valid) && $stable(done)))
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("outputs moved while stall was high");
    end

    result_hold: assert property (@(posedge clk) disable iff (rst)
        (!$stable(valid) || !$stable(key)) |-> done)
    else begin
        key_check_tb.assert_fails = key_check_tb.assert_fails + 1;
        $error("valid or key changed without a done pulse");
    end

endmodule

// File: logic/key_check.sv
module key_check import kb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      start,
    input  block128_t in_buf,
    input  kb_t       kb,
    output block128_t key,
    output logic      valid,
    output logic      done
);

    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_hash,
        s_decrypt
    } state_t;

    state_t    state;
    kb_t       kb_r;
    block128_t in_buf_r;     // ciphertext under test

    logic      msg_we;
    md5_addr_t msg_addr;
    word_t     msg_word;
    md5_addr_t next_addr;
    logic      md5_start;
    logic      md5_done;
    block128_t digest;

    logic      aes_start;
    logic      aes_done;
    block128_t aes_out;
    logic      match;

    // block word for index, pad words on top
    function automatic word_t word_sel(kb_t kb_v, md5_addr_t idx);
        case (idx)
            4'd14:   return md5_pad14;
            4'd15:   return md5_pad15;
            default: return kb_v[32 * idx +: 32];
        endcase
    endfunction

    assign next_addr = msg_addr + 4'd1;
    assign match     = (aes_out == digest);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= s_idle;
            msg_we    <= 1'b0;
            msg_addr  <= '0;
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            valid     <= 1'b0;
            key       <= '0;
            done      <= 1'b0;
        end else if (!stall) begin
            done      <= 1'b0;
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state    <= s_load;
                        msg_we   <= 1'b1;
                        msg_addr <= '0;
                    end
                end
                s_load: begin
                    if (msg_addr == 4'd15) begin
                        msg_we    <= 1'b0;
                        md5_start <= 1'b1;  // word 15 lands this edge
                        state     <= s_hash;
                    end else begin
                        msg_addr <= next_addr;
                    end
                end
                s_hash: begin
                    if (md5_done) begin
                        aes_start <= 1'b1;
                        state     <= s_decrypt;
                    end
                end
                s_decrypt: begin
                    if (aes_done) begin
                        valid <= match;
                        key   <= match ? digest : '0;
                        done  <= 1'b1;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if ((state == s_idle) && start) begin
                kb_r     <= kb;
                in_buf_r <= in_buf;
                msg_word <= word_sel(kb, 4'd0);
            end else if (state == s_load) begin
                msg_word <= word_sel(kb_r, next_addr);
            end
        end
    end

    md5_block u_md5 (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .msg_we   (msg_we),
        .msg_addr (msg_addr),
        .msg_word (msg_word),
        .start    (md5_start),
        .done     (md5_done),
        .digest   (digest)
    );

    aes_dec_core u_aes (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .start    (aes_start),
        .aes_key  (digest),     // hash is the aes key
        .aes_in   (in_buf_r),
        .done     (aes_done),
        .aes_out  (aes_out)
    );

endmodule

// File: logic/aes_dec_core.sv
module aes_dec_core import kb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      start,
    input  block128_t aes_key,
    input  block128_t aes_in,
    output logic      done,
    output block128_t aes_out
);

    typedef enum logic [1:0] {
        s_idle,
        s_expand,
        s_round
    } state_t;

    state_t     state;
    logic [3:0] cnt;        // expansions done, then round index
    block128_t  key_r;      // the only round key register
    block128_t  st_r;

    block128_t  fwd_in;
    block128_t  key_nxt;
    block128_t  sub_w;
    block128_t  mix_w;
    logic [3:0] inv_rc_idx;
    logic       last_rnd;

    // SubWord(RotWord(w))
    function automatic word_t sub_rot(word_t w);
        return {aes_sbox(w[23:16]), aes_sbox(w[15:8]), aes_sbox(w[7:0]), aes_sbox(w[31:24])};
    endfunction

    function automatic block128_t key_fwd(block128_t k, byte_t rc);
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        w0 = k[127:96] ^ sub_rot(k[31:0]) ^ {rc, 24'h0};
        w1 = k[95:64] ^ w0;
        w2 = k[63:32] ^ w1;
        w3 = k[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

    // undo one expansion step
    function automatic block128_t key_inv(block128_t k, byte_t rc);
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        w3 = k[31:0] ^ k[63:32];
        w2 = k[63:32] ^ k[95:64];
        w1 = k[95:64] ^ k[127:96];
        w0 = k[127:96] ^ sub_rot(w3) ^ {rc, 24'h0};
        return {w0, w1, w2, w3};
    endfunction

    function automatic block128_t inv_shift_rows(block128_t s);
        block128_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++)
                o[127 - 8 * (4 * c + r) -: 8] = s[127 - 8 * (4 * ((c - r + 4) % 4) + r) -: 8];
        end
        return o;
    endfunction

    function automatic block128_t inv_sub_bytes(block128_t s);
        block128_t o;
        for (int i = 0; i < 16; i++)
            o[127 - 8 * i -: 8] = aes_inv_sbox(s[127 - 8 * i -: 8]);
        return o;
    endfunction

    function automatic block128_t inv_mix_columns(block128_t s);
        block128_t o;
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s[127 - 32 * c -: 8];
            a1 = s[119 - 32 * c -: 8];
            a2 = s[111 - 32 * c -: 8];
            a3 = s[103 - 32 * c -: 8];
            o[127 - 32 * c -: 8] = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b)
                                 ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
            o[119 - 32 * c -: 8] = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e)
                                 ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
            o[111 - 32 * c -: 8] = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09)
                                 ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
            o[103 - 32 * c -: 8] = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d)
                                 ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
        end
        return o;
    endfunction

    // cnt is zero in idle, so the start edge uses rcon 1
    assign fwd_in     = (state == s_idle) ? aes_key : key_r;
    assign key_nxt    = key_fwd(fwd_in, aes_rcon(cnt + 4'd1));
    assign sub_w      = inv_sub_bytes(inv_shift_rows(st_r)) ^ key_r;
    assign mix_w      = inv_mix_columns(sub_w);
    assign inv_rc_idx = 4'(aes_rounds) - cnt;
    assign last_rnd   = (cnt == 4'(aes_rounds));
    assign aes_out    = st_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else if (!stall) begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_expand;
                        cnt   <= 4'd1;
                    end
                end
                s_expand: begin
                    if (cnt == 4'(aes_rounds - 1)) begin
                        state <= s_round;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                s_round: begin
                    if (last_rnd) begin
                        state <= s_idle;
                        cnt   <= '0;
                        done  <= 1'b1;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            case (state)
                s_idle: begin
                    if (start) begin
                        key_r <= key_nxt;
                        st_r  <= aes_in;
                    end
                end
                s_expand: key_r <= key_nxt;
                s_round: begin
                    if (cnt == 4'd0)
                        st_r <= st_r ^ key_r;  // initial AddRoundKey
                    else if (last_rnd)
                        st_r <= sub_w;         // no mix in the last round
                    else
                        st_r <= mix_w;
                    if (!last_rnd)
                        key_r <= key_inv(key_r, aes_rcon(inv_rc_idx));
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/md5_block.sv
module md5_block import kb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      msg_we,
    input  md5_addr_t msg_addr,
    input  word_t     msg_word,
    input  logic      start,
    output logic      done,
    output block128_t digest
);

    typedef enum logic [1:0] {
        s_idle,
        s_round,
        s_finish
    } state_t;

    state_t     state;
    logic [5:0] rnd;        // step index, zero while idle
    word_t      msg_buf [16];
    word_t      a_r;
    word_t      b_r;
    word_t      c_r;
    word_t      d_r;

    word_t      a_in;
    word_t      b_in;
    word_t      c_in;
    word_t      d_in;
    word_t      f_w;
    word_t      sum_w;
    word_t      b_nxt;
    logic       step_en;

    function automatic word_t rotl32(word_t x, logic [4:0] s);
        return word_t'((x << s) | (x >> (6'd32 - {1'b0, s})));
    endfunction

    // step zero runs on the start edge straight from the iv
    assign a_in = (state == s_idle) ? md5_iv_a : a_r;
    assign b_in = (state == s_idle) ? md5_iv_b : b_r;
    assign c_in = (state == s_idle) ? md5_iv_c : c_r;
    assign d_in = (state == s_idle) ? md5_iv_d : d_r;

    always_comb begin
        case (rnd[5:4])
            2'd0:    f_w = (b_in & c_in) | (~b_in & d_in);
            2'd1:    f_w = (d_in & b_in) | (~d_in & c_in);
            2'd2:    f_w = b_in ^ c_in ^ d_in;
            default: f_w = c_in ^ (b_in | ~d_in);
        endcase
    end

    assign sum_w   = a_in + f_w + md5_k(rnd) + msg_buf[md5_g(rnd)];
    assign b_nxt   = b_in + rotl32(sum_w, md5_s(rnd));
    assign step_en = ((state == s_idle) && start) || (state == s_round);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            rnd   <= '0;
            done  <= 1'b0;
        end else if (!stall) begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_round;
                        rnd   <= 6'd1;
                    end
                end
                s_round: begin
                    rnd <= rnd + 6'd1;  // wraps back to zero
                    if (rnd == 6'(md5_rounds - 1))
                        state <= s_finish;
                end
                s_finish: begin
                    done  <= 1'b1;
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (msg_we)
                msg_buf[msg_addr] <= msg_word;
            if (step_en) begin
                a_r <= d_in;
                b_r <= b_nxt;
                c_r <= b_in;
                d_r <= c_in;
            end
            if (state == s_finish)
                digest <= {a_r + md5_iv_a, b_r + md5_iv_b, c_r + md5_iv_c, d_r + md5_iv_d};
        end
    end

endmodule

// File: logic/kb_pkg.sv
package kb_pkg;

    typedef logic [31:0]  word_t;      // one md5 word
    typedef logic [127:0] block128_t;  // hash, aes key or aes state
    typedef logic [447:0] kb_t;        // key basis
    typedef logic [7:0]   byte_t;      // one aes byte
    typedef logic [3:0]   md5_addr_t;  // message buffer index

    localparam word_t md5_iv_a = 32'h6745_2301;
    localparam word_t md5_iv_b = 32'hefcd_ab89;
    localparam word_t md5_iv_c = 32'h98ba_dcfe;
    localparam word_t md5_iv_d = 32'h1032_5476;

    localparam word_t md5_pad14 = 32'h8000_0000;  // fixed pad word
    localparam word_t md5_pad15 = 32'h0000_0000;

    localparam int md5_rounds = 64;
    localparam int aes_rounds = 10;

    // sine derived step constants
    localparam word_t md5_k_tab [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // rotate amounts, four per group of 16 rounds
    localparam logic [4:0] md5_s_tab [16] = '{
        5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9,  5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21
    };

    function automatic word_t md5_k(logic [5:0] rnd);
        return md5_k_tab[rnd];
    endfunction

    function automatic logic [4:0] md5_s(logic [5:0] rnd);
        return md5_s_tab[{rnd[5:4], rnd[1:0]}];
    endfunction

    function automatic md5_addr_t md5_g(logic [5:0] rnd);
        case (rnd[5:4])
            2'd0:    return rnd[3:0];
            2'd1:    return md5_addr_t'(5 * rnd + 1);
            2'd2:    return md5_addr_t'(3 * rnd + 5);
            default: return md5_addr_t'(7 * rnd);
        endcase
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);  // xtime
        end
        return p;
    endfunction

    // x^254, which maps zero to zero
    function automatic byte_t gf_inv(byte_t x);
        byte_t r;
        r = x;
        for (int i = 0; i < 6; i++)
            r = gf_mul(gf_mul(r, r), x);
        return gf_mul(r, r);
    endfunction

    function automatic byte_t rotl8(byte_t x, int n);
        return byte_t'((x << n) | (x >> (8 - n)));
    endfunction

    function automatic byte_t aes_sbox(byte_t x);
        byte_t b;
        b = gf_inv(x);
        return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
    endfunction

    function automatic byte_t aes_inv_sbox(byte_t x);
        byte_t b;
        b = rotl8(x, 1) ^ rotl8(x, 3) ^ rotl8(x, 6) ^ 8'h05;  // inverse affine
        return gf_inv(b);
    endfunction

    function automatic byte_t aes_rcon(logic [3:0] idx);
        byte_t r;
        r = 8'h01;
        for (int j = 2; j <= aes_rounds; j++) begin
            if (j <= idx)
                r = gf_mul(r, 8'h02);
        end
        return r;
    endfunction

endpackage
